//--- build.f
hdl/sat_pkg.sv
hdl/sat_controller.sv
hdl/sat_counter.sv
hdl/sat_row_sum.sv
hdl/sat_line_buffer.sv
hdl/sat_top.sv
verification/sat_tb.sv

//--- hdl/sat_controller.sv
`timescale 1ns/1ns

module sat_controller #(
    parameter int COLS = 19,
    parameter int ROWS = 6
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_start,
    input  logic              i_pix_valid,
    input  logic              i_advance,
    input  logic              i_col_last,
    input  logic              i_row_last,
    input  logic              i_last_out,
    output logic              o_pix_ready,
    output logic              o_accept,
    output sat_pkg::cnt_op_e  o_cnt_op,
    output logic              o_clear_wr,
    output logic              o_row_start,
    output logic              o_frame_last,
    output logic              o_busy,
    output logic              o_frame_done
);

    localparam int FRAME_PIX = COLS * ROWS;
    localparam int PW = $clog2(FRAME_PIX + 1);

    sat_pkg::sat_state_e state_q;
    sat_pkg::sat_state_e state_d;
    logic                row_start_q;
    logic [PW-1:0]       pix_cnt;

    ////////////////////////////////////////////////////////////
    // state register and row-start flag
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= sat_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // column zero is reached after a clear or after the last column
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row_start_q <= 1'b1;
            pix_cnt     <= '0;
        end else if (state_q == sat_pkg::ST_CLEAR) begin
            row_start_q <= 1'b1;
            pix_cnt     <= '0;
        end else if (o_accept) begin
            row_start_q <= i_col_last;
            pix_cnt     <= pix_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // next state and outputs
    ////////////////////////////////////////////////////////////

    assign o_pix_ready  = (state_q == sat_pkg::ST_STREAM) && i_advance;
    assign o_accept     = o_pix_ready && i_pix_valid;
    assign o_row_start  = row_start_q;
    assign o_frame_last = i_col_last && i_row_last;

    always_comb begin
        state_d      = state_q;
        o_cnt_op     = sat_pkg::CNT_HOLD;
        o_clear_wr   = 1'b0;
        o_busy       = 1'b1;
        o_frame_done = 1'b0;
        case (state_q)
            sat_pkg::ST_IDLE: begin
                o_busy = 1'b0;
                if (i_start) begin
                    state_d = sat_pkg::ST_CLEAR;
                end
            end
            sat_pkg::ST_CLEAR: begin
                o_clear_wr = 1'b1;
                if (i_col_last) begin
                    o_cnt_op = sat_pkg::CNT_CLEAR;
                    state_d  = sat_pkg::ST_STREAM;
                end else begin
                    o_cnt_op = sat_pkg::CNT_STEP;
                end
            end
            sat_pkg::ST_STREAM: begin
                if (o_accept) begin
                    o_cnt_op = sat_pkg::CNT_STEP;
                    if (o_frame_last) begin
                        state_d = sat_pkg::ST_DRAIN;
                    end
                end
            end
            sat_pkg::ST_DRAIN: begin
                // the last table value is still in the two stages
                if (i_last_out) begin
                    state_d = sat_pkg::ST_FINISH;
                end
            end
            sat_pkg::ST_FINISH: begin
                o_frame_done = 1'b1;
                state_d      = sat_pkg::ST_IDLE;
            end
            default: begin
                state_d = sat_pkg::ST_IDLE;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    a_done_single: assert property (@(posedge clk) disable iff (rst)
        o_frame_done |=> !o_frame_done);

    a_accept_stream: assert property (@(posedge clk) disable iff (rst)
        o_accept |-> state_q == sat_pkg::ST_STREAM);

    // the counter's last flags agree with the number of pixels taken
    a_frame_count: assert property (@(posedge clk) disable iff (rst)
        (o_accept && o_frame_last) |-> pix_cnt == PW'(FRAME_PIX - 1));

endmodule

//--- hdl/sat_counter.sv
`timescale 1ns/1ns

module sat_counter #(
    parameter int COLS = 19,
    parameter int ROWS = 6
) (
    input  logic                     clk,
    input  logic                     rst,
    input  sat_pkg::cnt_op_e         i_op,
    output logic [$clog2(COLS)-1:0]  o_col,
    output logic [$clog2(ROWS)-1:0]  o_row,
    output logic                     o_col_last,
    output logic                     o_row_last
);

    localparam int CW = $clog2(COLS);
    localparam int RW = $clog2(ROWS);

    assign o_col_last = (o_col == CW'(COLS - 1));
    assign o_row_last = (o_row == RW'(ROWS - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_col <= '0;
            o_row <= '0;
        end else begin
            case (i_op)
                sat_pkg::CNT_CLEAR: begin
                    o_col <= '0;
                    o_row <= '0;
                end
                sat_pkg::CNT_STEP: begin
                    if (o_col_last) begin
                        o_col <= '0;
                        // the row wraps too so a finished frame leaves both at zero
                        o_row <= o_row_last ? '0 : o_row + 1'b1;
                    end else begin
                        o_col <= o_col + 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    a_col_range: assert property (@(posedge clk) disable iff (rst)
        o_col < CW'(COLS));

endmodule

//--- hdl/sat_line_buffer.sv
`timescale 1ns/1ns

module sat_line_buffer #(
    parameter int COLS  = 19,
    parameter int SUM_W = 20
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_valid,
    input  logic [SUM_W-1:0]         i_sum,
    input  logic                     i_first_col,
    input  logic [$clog2(COLS)-1:0]  i_col,
    input  logic                     i_clear_wr,
    input  logic                     i_last_item,
    input  logic                     i_sat_ready,
    output logic                     o_ready,
    output logic                     o_sat_valid,
    output logic [SUM_W-1:0]         o_sat_data,
    output logic                     o_sat_last
);

    localparam int CW = $clog2(COLS);

    logic [SUM_W-1:0] mem [COLS];
    logic [CW-1:0]    wr_ptr;
    logic [SUM_W-1:0] sat_next;
    logic             move;

    assign o_ready  = ~o_sat_valid | i_sat_ready;
    assign move     = i_valid & o_ready;
    assign sat_next = i_sum + mem[wr_ptr];

    ////////////////////////////////////////////////////////////
    // pointer and output control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr      <= '0;
            o_sat_valid <= 1'b0;
            o_sat_last  <= 1'b0;
        end else begin
            if (i_clear_wr) begin
                wr_ptr <= '0;
            end else if (move) begin
                wr_ptr <= (wr_ptr == CW'(COLS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (move) begin
                o_sat_valid <= 1'b1;
                o_sat_last  <= i_last_item;
            end else if (i_sat_ready) begin
                o_sat_valid <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // row storage
    ////////////////////////////////////////////////////////////

    // writing the table value back turns the stored row into the current one
    always_ff @(posedge clk) begin
        if (i_clear_wr) begin
            mem[i_col] <= '0;
        end else if (move) begin
            mem[wr_ptr] <= sat_next;
        end
        if (move) begin
            o_sat_data <= sat_next;
        end
    end

    a_clear_idle: assert property (@(posedge clk) disable iff (rst)
        !(i_clear_wr && i_valid));

    // the first column of a row always lands at word zero
    a_first_col_ptr: assert property (@(posedge clk) disable iff (rst)
        (i_valid && i_first_col) |-> wr_ptr == '0);

endmodule

//--- hdl/sat_pkg.sv
package sat_pkg;

    ////////////////////////////////////////////////////////////
    // controller states
    ////////////////////////////////////////////////////////////

    // five states need three bits
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_STREAM,
        ST_DRAIN,
        ST_FINISH
    } sat_state_e;

    ////////////////////////////////////////////////////////////
    // counter opcodes
    ////////////////////////////////////////////////////////////

    // step wraps the column into the next row at the last column
    typedef enum logic [1:0] {
        CNT_HOLD,
        CNT_CLEAR,
        CNT_STEP
    } cnt_op_e;

endpackage

//--- hdl/sat_row_sum.sv
`timescale 1ns/1ns

module sat_row_sum #(
    parameter int PIX_W = 8,
    parameter int SUM_W = 20
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_accept,
    input  logic [PIX_W-1:0]  i_pix_data,
    input  logic              i_row_start,
    input  logic              i_frame_last,
    input  logic              i_ready,
    output logic              o_advance,
    output logic              o_valid,
    output logic [SUM_W-1:0]  o_sum,
    output logic              o_first_col,
    output logic              o_last_item
);

    // free when empty or when the line buffer takes the current item
    assign o_advance = ~o_valid | i_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else if (i_accept) begin
            o_valid <= 1'b1;
        end else if (i_ready) begin
            o_valid <= 1'b0;
        end
    end

    // a new row restarts the running sum at the pixel itself
    always_ff @(posedge clk) begin
        if (i_accept) begin
            o_sum       <= i_row_start ? SUM_W'(i_pix_data) : o_sum + SUM_W'(i_pix_data);
            o_first_col <= i_row_start;
            o_last_item <= i_frame_last;
        end
    end

endmodule

//--- hdl/sat_top.sv
`timescale 1ns/1ns

module sat_top #(
    parameter int COLS  = 19,
    parameter int ROWS  = 6,
    parameter int PIX_W = 8,
    parameter int SUM_W = 20
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_start,
    input  logic              i_pix_valid,
    output logic              o_pix_ready,
    input  logic [PIX_W-1:0]  i_pix_data,
    output logic              o_sat_valid,
    input  logic              i_sat_ready,
    output logic [SUM_W-1:0]  o_sat_data,
    output logic              o_sat_last,
    output logic              o_busy,
    output logic              o_frame_done
);

    localparam int CW = $clog2(COLS);

    sat_pkg::cnt_op_e  cnt_op;
    logic [CW-1:0]     col;
    logic              col_last;
    logic              row_last;
    logic              clear_wr;
    logic              accept;
    logic              advance;
    logic              row_start;
    logic              frame_last;
    logic              rs_valid;
    logic [SUM_W-1:0]  rs_sum;
    logic              rs_first_col;
    logic              rs_last_item;
    logic              lb_ready;
    logic              last_out;

    assign last_out = o_sat_valid & i_sat_ready & o_sat_last;

    sat_controller #(.COLS(COLS), .ROWS(ROWS)) u_ctrl (
        .clk(clk), .rst(rst), .i_start(i_start), .i_pix_valid(i_pix_valid),
        .i_advance(advance), .i_col_last(col_last), .i_row_last(row_last),
        .i_last_out(last_out), .o_pix_ready(o_pix_ready), .o_accept(accept),
        .o_cnt_op(cnt_op), .o_clear_wr(clear_wr), .o_row_start(row_start),
        .o_frame_last(frame_last), .o_busy(o_busy), .o_frame_done(o_frame_done)
    );

    sat_counter #(.COLS(COLS), .ROWS(ROWS)) u_cnt (
        .clk(clk), .rst(rst), .i_op(cnt_op), .o_col(col), .o_row(),
        .o_col_last(col_last), .o_row_last(row_last)
    );

    sat_row_sum #(.PIX_W(PIX_W), .SUM_W(SUM_W)) u_row_sum (
        .clk(clk), .rst(rst), .i_accept(accept), .i_pix_data(i_pix_data),
        .i_row_start(row_start), .i_frame_last(frame_last), .i_ready(lb_ready),
        .o_advance(advance), .o_valid(rs_valid), .o_sum(rs_sum),
        .o_first_col(rs_first_col), .o_last_item(rs_last_item)
    );

    sat_line_buffer #(.COLS(COLS), .SUM_W(SUM_W)) u_line_buf (
        .clk(clk), .rst(rst), .i_valid(rs_valid), .i_sum(rs_sum),
        .i_first_col(rs_first_col), .i_col(col), .i_clear_wr(clear_wr),
        .i_last_item(rs_last_item), .i_sat_ready(i_sat_ready), .o_ready(lb_ready),
        .o_sat_valid(o_sat_valid), .o_sat_data(o_sat_data), .o_sat_last(o_sat_last)
    );

endmodule

//--- verification/sat_tb.sv
`timescale 1ns/1ns

module sat_tb;

    localparam int COLS      = 19;
    localparam int ROWS      = 6;
    localparam int PIX_W     = 8;
    localparam int SUM_W     = 20;
    localparam int N         = ROWS * COLS;
    localparam int RESET_CYC = 16;
    localparam int FRAMES    = 4;

    logic             clk;
    logic             rst;
    logic             i_start;
    logic             i_pix_valid;
    logic             o_pix_ready;
    logic [PIX_W-1:0] i_pix_data;
    logic             o_sat_valid;
    logic             i_sat_ready;
    logic [SUM_W-1:0] o_sat_data;
    logic             o_sat_last;
    logic             o_busy;
    logic             o_frame_done;

    logic [31:0]      rng_state;
    int               errors;
    int               tests_run;
    int               tests_failed;
    int               err_mark;
    int unsigned      pix_q[$];
    longint           model[N];
    int               in_cyc[N];

    sat_top #(.COLS(COLS), .ROWS(ROWS), .PIX_W(PIX_W), .SUM_W(SUM_W)) uut (
        .clk(clk), .rst(rst), .i_start(i_start), .i_pix_valid(i_pix_valid),
        .o_pix_ready(o_pix_ready), .i_pix_data(i_pix_data), .o_sat_valid(o_sat_valid),
        .i_sat_ready(i_sat_ready), .o_sat_data(o_sat_data), .o_sat_last(o_sat_last),
        .o_busy(o_busy), .o_frame_done(o_frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // every frame is far shorter than twenty cycles per pixel
    initial begin
        sat_pkg::sat_state_e st;
        #((RESET_CYC + FRAMES * N * 20) * 10);
        st = uut.u_ctrl.state_q;
        $display("timeout: the run did not finish in time, controller stuck in %s", st.name());
        $display("=== FAIL ===");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic int unsigned next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[31:8];
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("error at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    // table values from the usual four-term recurrence
    task automatic build_model();
        int idx;
        pix_q.delete();
        for (int i = 0; i < N; i++) begin
            pix_q.push_back(next_rand() % (1 << PIX_W));
        end
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                idx = r * COLS + c;
                model[idx] = pix_q[idx];
                if (r > 0) model[idx] += model[idx - COLS];
                if (c > 0) model[idx] += model[idx - 1];
                if (r > 0 && c > 0) model[idx] -= model[idx - COLS - 1];
            end
        end
    endtask

    task automatic start_frame();
        int edges;
        @(negedge clk);
        i_pix_valid = 1'b0;
        i_sat_ready = 1'b1;
        i_start     = 1'b1;
        edges       = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            i_start = 1'b0;
        end while (!o_pix_ready);
        check("o_pix_ready rise cycle", COLS + 1, edges);
    endtask

    // drives one frame and checks every output transfer as it is seen
    task automatic run_frame(input int valid_pct, input int ready_pct, input bit poke_start);
        int sent;
        int recv;
        int cyc;
        int last_cyc;
        int done_cnt;
        int done_cyc;
        int tail;
        bit pending;
        bit in_x;
        bit out_x;
        build_model();
        start_frame();
        sent     = 0;
        recv     = 0;
        cyc      = 0;
        last_cyc = -1;
        done_cyc = -1;
        done_cnt = 0;
        tail     = 0;
        pending  = 1'b0;
        while (tail < 4) begin
            i_pix_valid = pending || (sent < N && next_rand() % 100 < valid_pct);
            i_pix_data  = (sent < N) ? PIX_W'(pix_q[sent]) : '0;
            i_sat_ready = next_rand() % 100 < ready_pct;
            i_start     = poke_start && sent == N / 2;
            #1;
            if (i_start) check("o_busy", 1, o_busy);
            if (o_frame_done) begin
                done_cnt++;
                done_cyc = cyc;
            end
            in_x    = i_pix_valid && o_pix_ready;
            out_x   = o_sat_valid && i_sat_ready;
            pending = i_pix_valid && !in_x;
            if (in_x) begin
                in_cyc[sent] = cyc;
                sent++;
            end
            if (out_x && recv >= N) begin
                $display("error at %0t ns: an output came after the frame was complete", $time);
                errors++;
            end else if (out_x) begin
                check("o_sat_data", model[recv], o_sat_data);
                check("o_sat_last", recv == N - 1, o_sat_last);
                if (valid_pct >= 100 && ready_pct >= 100) begin
                    check("output latency", 2, cyc - in_cyc[recv]);
                end
                if (recv == N - 1) last_cyc = cyc;
                recv++;
            end
            if (recv == N) tail++;
            cyc++;
            @(negedge clk);
        end
        check("o_frame_done pulse count", 1, done_cnt);
        check("o_frame_done cycle", last_cyc + 1, done_cyc);
        check("o_busy", 0, o_busy);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rng_state    = 32'd89154;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_mark     = 0;
        rst          = 1'b1;
        i_start      = 1'b0;
        i_pix_valid  = 1'b0;
        i_pix_data   = '0;
        i_sat_ready  = 1'b0;
        repeat (RESET_CYC) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check("o_pix_ready", 0, o_pix_ready);
        check("o_sat_valid", 0, o_sat_valid);
        check("o_frame_done", 0, o_frame_done);
        check("o_busy", 0, o_busy);
        report_test("reset state");
        run_frame(100, 100, 1'b0);
        report_test("full rate frame");
        run_frame(70, 70, 1'b0);
        report_test("random handshake frame");
        // a start pulse in the middle of each frame must be ignored
        run_frame(70, 70, 1'b1);
        run_frame(70, 70, 1'b1);
        report_test("back to back frames");
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
